/* hw/uart_pkg.sv */
package uart_pkg;

    // Frame payload width shared by both directions and by the item structs
    localparam int DATA_BITS = 8;

    // Ticks per bit period used by the receiver phase counter and the transmitter divider
    localparam int OVERSAMPLE = 16;

    // Error flags attached to every received byte
    typedef struct packed {
        logic overrun;  // Set on the first item stored after a dropped frame
        logic brk;      // Data, parity and every stop bit were low
        logic parity;   // Parity bit does not match even parity of the data
        logic frame;    // At least one stop bit was sampled low
    } rx_err_t;

    // One entry of the receive queue as seen by the host
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        rx_err_t              err;
    } rx_item_t;

    // Receiver FSM walks the frame one sampled bit at a time
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_DONE     // Single cycle in which the item is handed over
    } rx_state_e;

    // Transmitter FSM holds each state for whole bit periods
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

endpackage

/* hw/uart_fifo.sv */
module uart_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             Clk,
    input  logic             Rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];  // Circular storage addressed by the two pointers
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // DEPTH is a power of two so the pointer wraps by itself
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];  // Oldest entry is visible without a read cycle
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    // Callers must look at the flags before they push or pop
    a_no_push_full: assert property (@(posedge Clk) disable iff (Rst) push |-> !full);
    a_no_pop_empty: assert property (@(posedge Clk) disable iff (Rst) pop |-> !empty);

endmodule

/* hw/uart_rx.sv */
module uart_rx #(
    parameter int STOP_BITS     = 1,
    parameter int CLKS_PER_TICK = 4
) (
    input  logic              Clk,
    input  logic              Rst,
    input  logic              rx_line,
    output logic              rx_done,
    output uart_pkg::rx_item_t rx_item,
    output logic              idle
);

    localparam int DIV_W   = $clog2(CLKS_PER_TICK);
    localparam int PHASE_W = $clog2(uart_pkg::OVERSAMPLE);
    localparam int BIT_W   = $clog2(uart_pkg::DATA_BITS);

    uart_pkg::rx_state_e state;

    logic                          rx_meta;     // First synchronizer stage
    logic                          rx_sync;     // Line value safe to use in this clock domain
    logic                          rx_prev;     // Previous synchronized value for edge detection
    logic                          fall;
    logic [DIV_W-1:0]              div_cnt;
    logic [PHASE_W-1:0]            phase;       // Position inside the current bit in ticks
    logic                          tick;
    logic                          sample;      // Middle of the current bit
    logic [BIT_W-1:0]              bit_cnt;     // Data bit index then stop bit index
    logic [uart_pkg::DATA_BITS-1:0] data_sr;
    logic                          par_bit;
    logic                          stop_low;    // Some stop bit was low
    logic                          stop_high;   // Some stop bit was high

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_meta <= 1'b1;  // Idle line level so no false start comes out of reset
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall   = rx_prev && !rx_sync;
    assign tick   = (div_cnt == DIV_W'(CLKS_PER_TICK - 1));
    assign sample = tick && (phase == PHASE_W'(uart_pkg::OVERSAMPLE / 2 - 1));

    // Divider and phase sit at zero in IDLE so every start edge restarts the bit timing
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            div_cnt <= '0;
            phase   <= '0;
        end else if (state == uart_pkg::RX_IDLE) begin
            div_cnt <= '0;
            phase   <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            phase   <= (phase == PHASE_W'(uart_pkg::OVERSAMPLE - 1)) ? '0 : phase + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state   <= uart_pkg::RX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (fall) state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: begin
                    if (sample) begin
                        bit_cnt <= '0;
                        // A line back high at mid start bit was only a glitch
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (sample) begin
                        if (bit_cnt == BIT_W'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::RX_PARITY;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::RX_PARITY: begin
                    if (sample) begin
                        state   <= uart_pkg::RX_STOP;
                        bit_cnt <= '0;  // Reused to count the stop bits
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (sample) begin
                        if (bit_cnt == BIT_W'(STOP_BITS - 1)) begin
                            state <= uart_pkg::RX_DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= uart_pkg::RX_IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (sample) begin
            case (state)
                uart_pkg::RX_START: begin
                    stop_low  <= 1'b0;  // Fresh stop flags for the new frame
                    stop_high <= 1'b0;
                end
                uart_pkg::RX_DATA:   data_sr <= {data_sr[uart_pkg::DATA_BITS-2:0], rx_sync};
                uart_pkg::RX_PARITY: par_bit <= rx_sync;
                uart_pkg::RX_STOP: begin
                    stop_low  <= stop_low | !rx_sync;
                    stop_high <= stop_high | rx_sync;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        rx_item.data        = data_sr;
        rx_item.err.overrun = 1'b0;                      // Only the host port knows about drops
        rx_item.err.parity  = par_bit ^ (^data_sr);      // Even parity expected
        rx_item.err.frame   = stop_low;
        rx_item.err.brk     = !(|data_sr) && !par_bit && !stop_high;
    end

    assign rx_done = (state == uart_pkg::RX_DONE);
    assign idle    = (state == uart_pkg::RX_IDLE);

    // Each frame is handed over exactly once
    a_done_single: assert property (@(posedge Clk) disable iff (Rst) rx_done |=> !rx_done);

endmodule

/* hw/uart_tx.sv */
module uart_tx #(
    parameter int STOP_BITS     = 1,
    parameter int CLKS_PER_TICK = 4
) (
    input  logic                          Clk,
    input  logic                          Rst,
    input  logic                          tx_start,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_byte,
    input  logic                          cts,
    output logic                          tx_busy,
    output logic                          tx_line
);

    localparam int BIT_CLKS = CLKS_PER_TICK * uart_pkg::OVERSAMPLE;  // Clock cycles per bit
    localparam int CLK_W    = $clog2(BIT_CLKS);
    localparam int BIT_W    = $clog2(uart_pkg::DATA_BITS);

    uart_pkg::tx_state_e state;

    logic [CLK_W-1:0]               clk_cnt;
    logic                           bit_end;   // Last cycle of the current bit
    logic [BIT_W-1:0]               bit_cnt;   // Data bit index then stop bit index
    logic                           launch;
    logic [uart_pkg::DATA_BITS-1:0] shreg;
    logic                           par;

    assign bit_end = (clk_cnt == CLK_W'(BIT_CLKS - 1));
    assign launch  = (state == uart_pkg::TX_IDLE) && tx_start && cts;  // No new frame while cts is low

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state   <= uart_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            if (state == uart_pkg::TX_IDLE || bit_end) begin
                clk_cnt <= '0;  // Held at zero in IDLE so the start bit gets a full period
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (launch) state <= uart_pkg::TX_START;
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_cnt <= '0;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_W'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::TX_PARITY;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_PARITY: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_STOP;
                        bit_cnt <= '0;
                    end
                end
                default: begin  // Stop bits
                    if (bit_end) begin
                        if (bit_cnt == BIT_W'(STOP_BITS - 1)) begin
                            state <= uart_pkg::TX_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (launch) begin
            shreg <= tx_byte;
            par   <= ^tx_byte;  // Even parity over the data bits
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shreg <= {shreg[uart_pkg::DATA_BITS-2:0], 1'b0};  // Next bit moves up to the MSB
        end
    end

    always_comb begin
        case (state)
            uart_pkg::TX_START:  tx_line = 1'b0;
            uart_pkg::TX_DATA:   tx_line = shreg[uart_pkg::DATA_BITS-1];
            uart_pkg::TX_PARITY: tx_line = par;
            default:             tx_line = 1'b1;  // Idle and stop bits are high
        endcase
    end

    assign tx_busy = (state != uart_pkg::TX_IDLE);

    // The host port must respect busy and cts when it launches a byte
    a_start_legal: assert property (@(posedge Clk) disable iff (Rst) tx_start |-> !tx_busy && cts);

endmodule

/* hw/uart_host_port.sv */
module uart_host_port #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          Clk,
    input  logic                          Rst,
    input  logic                          tx_valid,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    output logic                          tx_credit,
    input  logic                          rx_credit,
    output logic                          rx_valid,
    output uart_pkg::rx_item_t             rx_item,
    input  logic                          rx_done,
    input  uart_pkg::rx_item_t             rx_in_item,
    input  logic                          rx_idle,
    output logic                          tx_start,
    output logic [uart_pkg::DATA_BITS-1:0] tx_byte,
    input  logic                          tx_busy,
    input  logic                          cts,
    output logic                          rts
);

    localparam int CREDIT_W = 8;                       // Receive credits the host may bank
    localparam int MIRROR_W = $clog2(FIFO_DEPTH + 1);

    logic               txq_empty;
    logic               txq_full;
    logic               rxq_push;
    logic               rxq_empty;
    logic               rxq_full;
    uart_pkg::rx_item_t rxq_in;
    logic               ovr_sticky;   // A frame was dropped since the last stored item
    logic [CREDIT_W-1:0] rx_cred;
    logic [MIRROR_W-1:0] host_cred;   // Copy of the host's transmit credit count

    // Launch whenever a byte waits and the transmitter may start
    assign tx_start  = !txq_empty && !tx_busy && cts;
    assign tx_credit = tx_start;  // The popped entry frees one slot for the host

    uart_fifo #(
        .WIDTH (uart_pkg::DATA_BITS),
        .DEPTH (FIFO_DEPTH)
    ) i_tx_fifo (
        .Clk       (Clk),
        .Rst       (Rst),
        .push      (tx_valid),
        .push_data (tx_data),
        .pop       (tx_start),
        .pop_data  (tx_byte),
        .empty     (txq_empty),
        .full      (txq_full)
    );

    always_comb begin
        rxq_in             = rx_in_item;
        rxq_in.err.overrun = ovr_sticky;  // Pending drop is reported on this item
    end

    assign rxq_push = rx_done && !rxq_full;  // A frame arriving into a full queue is lost
    assign rx_valid = (rx_cred != '0) && !rxq_empty;

    uart_fifo #(
        .WIDTH ($bits(uart_pkg::rx_item_t)),
        .DEPTH (FIFO_DEPTH)
    ) i_rx_fifo (
        .Clk       (Clk),
        .Rst       (Rst),
        .push      (rxq_push),
        .push_data (rxq_in),
        .pop       (rx_valid),
        .pop_data  (rx_item),
        .empty     (rxq_empty),
        .full      (rxq_full)
    );

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            ovr_sticky <= 1'b0;
            rx_cred    <= '0;
            host_cred  <= MIRROR_W'(FIFO_DEPTH);
        end else begin
            if (rx_done && rxq_full) begin
                ovr_sticky <= 1'b1;
            end else if (rxq_push) begin
                ovr_sticky <= 1'b0;  // Merged into the item just stored
            end
            rx_cred   <= rx_cred + CREDIT_W'(rx_credit) - CREDIT_W'(rx_valid);
            host_cred <= host_cred + MIRROR_W'(tx_credit) - MIRROR_W'(tx_valid);
        end
    end

    // Ready to send only when idle and with room for one more frame
    assign rts = rx_idle && !rxq_full;

    // Credit discipline on the host side also keeps the transmit queue from overflowing
    a_tx_credit: assert property (@(posedge Clk) disable iff (Rst)
        tx_valid |-> (host_cred != '0) && !txq_full);

endmodule

/* hw/uart_link.sv */
module uart_link #(
    parameter int STOP_BITS     = 1,
    parameter int CLKS_PER_TICK = 4,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                          Clk,
    input  logic                          Rst,
    input  logic                          rx_line,
    output logic                          tx_line,
    input  logic                          cts,
    output logic                          rts,
    input  logic                          tx_valid,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    output logic                          tx_credit,
    input  logic                          rx_credit,
    output logic                          rx_valid,
    output uart_pkg::rx_item_t             rx_item
);

    logic                           rx_done;
    uart_pkg::rx_item_t             rx_in_item;  // Item as decoded from the line
    logic                           rx_idle;
    logic                           tx_start;
    logic [uart_pkg::DATA_BITS-1:0] tx_byte;
    logic                           tx_busy;

    uart_rx #(
        .STOP_BITS     (STOP_BITS),
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) i_rx (
        .Clk     (Clk),
        .Rst     (Rst),
        .rx_line (rx_line),
        .rx_done (rx_done),
        .rx_item (rx_in_item),
        .idle    (rx_idle)
    );

    uart_tx #(
        .STOP_BITS     (STOP_BITS),
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) i_tx (
        .Clk      (Clk),
        .Rst      (Rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .cts      (cts),
        .tx_busy  (tx_busy),
        .tx_line  (tx_line)
    );

    uart_host_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_host_port (
        .Clk        (Clk),
        .Rst        (Rst),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_credit  (tx_credit),
        .rx_credit  (rx_credit),
        .rx_valid   (rx_valid),
        .rx_item    (rx_item),
        .rx_done    (rx_done),
        .rx_in_item (rx_in_item),
        .rx_idle    (rx_idle),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .tx_busy    (tx_busy),
        .cts        (cts),
        .rts        (rts)
    );

endmodule

/* sim/uart_link_tests.svh */
`ifndef UART_LINK_TESTS_SVH
`define UART_LINK_TESTS_SVH

// Even parity bit computed bit by bit
function automatic logic even_par(input logic [uart_pkg::DATA_BITS-1:0] d);
    logic p;
    p = 1'b0;
    for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
        p = p ^ d[i];
    end
    return p;
endfunction

function automatic uart_pkg::rx_item_t make_item(input logic [uart_pkg::DATA_BITS-1:0] d,
                                                 input logic ovr, input logic brk,
                                                 input logic par, input logic frm);
    uart_pkg::rx_item_t item;
    item.data        = d;
    item.err.overrun = ovr;
    item.err.brk     = brk;
    item.err.parity  = par;
    item.err.frame   = frm;
    return item;
endfunction

task automatic set_loopback(input logic on);
    @(posedge Clk);
    loopback <= on;
endtask

task automatic grant_rx_credits(input int n);
    repeat (n) begin
        @(posedge Clk);
        rx_credit <= 1'b1;  // One pulse per granted delivery
    end
    @(posedge Clk);
    rx_credit <= 1'b0;
endtask

// Pushes one byte once the host holds a transmit credit
task automatic send_byte(input logic [uart_pkg::DATA_BITS-1:0] b);
    int waited;
    waited = 0;
    @(posedge Clk);
    while (FIFO_DEPTH + tx_credit_cnt - tx_sent <= 0) begin
        @(posedge Clk);
        waited++;
        assert (waited < 4 * FRAME_CYCLES) else fail_run("No transmit credit came back in time");
    end
    tx_valid <= 1'b1;
    tx_data  <= b;
    tx_sent++;
    @(posedge Clk);
    tx_valid <= 1'b0;
endtask

task automatic wait_items(input string name, input int n, input int frames);
    int cycles;
    cycles = 0;
    while (rx_q.size() < n) begin
        @(negedge Clk);  // Queue and counters are stable here
        cycles++;
        assert (cycles < frames * FRAME_CYCLES * 2) else
            fail_run($sformatf("%s: only %0d of %0d items arrived in time", name, rx_q.size(), n));
    end
endtask

task automatic check_next(input string name, input uart_pkg::rx_item_t expected);
    check_eq(name, expected, rx_q.pop_front());
endtask

task automatic test_reset_state();
    @(negedge Clk);
    check_eq("reset_state tx_line", 1, tx_line);
    check_eq("reset_state rts", 1, rts);
    check_eq("reset_state tx_credit", 0, tx_credit);
    check_eq("reset_state rx_valid", 0, rx_valid);
endtask

task automatic test_loopback_stream();
    logic [uart_pkg::DATA_BITS-1:0] bytes [8];
    int                             credits_before;
    set_loopback(1'b1);
    grant_rx_credits(8);
    credits_before = tx_credit_cnt;
    for (int i = 0; i < 8; i++) begin
        bytes[i] = 8'($urandom());
        send_byte(bytes[i]);
    end
    wait_items("loopback_stream", 8, 8);
    for (int i = 0; i < 8; i++) begin
        check_next("loopback_stream", make_item(bytes[i], 0, 0, 0, 0));
    end
    check_eq("loopback_stream tx_credit pulses", 8, tx_credit_cnt - credits_before);
endtask

task automatic test_line_errors();
    set_loopback(1'b0);
    grant_rx_credits(3);
    send_frame(8'hA5, !even_par(8'hA5), 2'b11);  // Wrong parity bit
    send_frame(8'h3C, even_par(8'h3C), 2'b10);   // First stop bit low
    send_frame(8'h00, 1'b0, 2'b00);              // Line held low for a whole frame
    wait_items("line_errors", 3, 2);
    check_next("line_errors parity", make_item(8'hA5, 0, 0, 1, 0));
    check_next("line_errors frame", make_item(8'h3C, 0, 0, 0, 1));
    check_next("line_errors break", make_item(8'h00, 0, 1, 0, 1));
endtask

task automatic test_glitch_reject();
    grant_rx_credits(1);
    @(posedge Clk);
    drv_line <= 1'b0;
    repeat (BIT_CLKS / 4) @(posedge Clk);  // Well short of half a bit
    drv_line <= 1'b1;
    repeat (FRAME_CYCLES) @(negedge Clk);  // A false start would have finished its frame by now
    check_eq("glitch_reject items", 0, rx_q.size());
    check_eq("glitch_reject rts", 1, rts);
    // Receiver must still take the next real frame
    send_frame(8'h5A, even_par(8'h5A), 2'b11);
    wait_items("glitch_reject", 1, 2);
    check_next("glitch_reject", make_item(8'h5A, 0, 0, 0, 0));
endtask

task automatic test_flow_control();
    logic [uart_pkg::DATA_BITS-1:0] bytes [6];
    int                             low_cycles;
    int                             cycles;
    set_loopback(1'b1);
    for (int i = 0; i < 6; i++) begin
        bytes[i] = 8'($urandom());
        send_byte(bytes[i]);
    end
    // Reception keeps rts low for less than a frame while a full queue keeps it low for good
    low_cycles = 0;
    cycles     = 0;
    while (low_cycles < FRAME_CYCLES + BIT_CLKS) begin
        @(negedge Clk);
        cycles++;
        low_cycles = rts ? 0 : low_cycles + 1;
        assert (cycles < 8 * FRAME_CYCLES) else
            fail_run("flow_control: rts did not stay low with the receive queue full");
    end
    check_eq("flow_control items before credits", 0, rx_q.size());
    grant_rx_credits(6);
    wait_items("flow_control", 6, 8);
    for (int i = 0; i < 6; i++) begin
        check_next("flow_control", make_item(bytes[i], 0, 0, 0, 0));
    end
endtask

task automatic test_overrun();
    logic [uart_pkg::DATA_BITS-1:0] bytes [6];
    set_loopback(1'b0);
    for (int i = 0; i < 5; i++) begin
        bytes[i] = 8'($urandom());
        send_frame(bytes[i], even_par(bytes[i]), 2'b11);  // Fifth one finds the queue full
    end
    grant_rx_credits(4);
    wait_items("overrun drain", 4, 2);
    for (int i = 0; i < 4; i++) begin
        check_next("overrun drain", make_item(bytes[i], 0, 0, 0, 0));
    end
    bytes[5] = 8'($urandom());
    send_frame(bytes[5], even_par(bytes[5]), 2'b11);
    grant_rx_credits(1);
    wait_items("overrun flag", 1, 2);
    check_next("overrun flag", make_item(bytes[5], 1, 0, 0, 0));
endtask

`endif

/* sim/uart_link_tb.sv */
module uart_link_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STOP_BITS     = 2;
    localparam int CLKS_PER_TICK = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int BIT_CLKS      = CLKS_PER_TICK * uart_pkg::OVERSAMPLE;  // Cycles per bit
    localparam int FRAME_BITS    = 1 + uart_pkg::DATA_BITS + 1 + STOP_BITS;
    localparam int FRAME_CYCLES  = FRAME_BITS * BIT_CLKS;
    localparam int TOTAL_FRAMES  = 8 + 3 + 1 + 6 + 6;  // Frames sent by all tests together
    // Whole run budget with a factor of two margin
    localparam int WATCHDOG_NS   = (TOTAL_FRAMES * FRAME_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;

    logic                           Clk;
    logic                           Rst;
    logic                           rx_line;
    logic                           tx_line;
    logic                           cts;
    logic                           rts;
    logic                           tx_valid;
    logic [uart_pkg::DATA_BITS-1:0] tx_data;
    logic                           tx_credit;
    logic                           rx_credit;
    logic                           rx_valid;
    uart_pkg::rx_item_t             rx_item;

    logic               loopback;    // Line model select
    logic               drv_line;    // Serial driver output used when loopback is off
    uart_pkg::rx_item_t rx_q [$];    // Every item the host has accepted in arrival order
    int                 tx_credit_cnt = 0;
    int                 tx_sent = 0;

    // Loopback ties the core to itself while the driver task owns the line and cts stays high
    assign rx_line = loopback ? tx_line : drv_line;
    assign cts     = loopback ? rts : 1'b1;

    uart_link #(
        .STOP_BITS     (STOP_BITS),
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) i_dut (
        .Clk       (Clk),
        .Rst       (Rst),
        .rx_line   (rx_line),
        .tx_line   (tx_line),
        .cts       (cts),
        .rts       (rts),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .rx_credit (rx_credit),
        .rx_valid  (rx_valid),
        .rx_item   (rx_item)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // Host side monitor accepts each delivery and counts returned transmit credits
    always @(posedge Clk) begin
        if (!Rst) begin
            if (rx_valid) begin
                rx_q.push_back(rx_item);
            end
            if (tx_credit) begin
                tx_credit_cnt <= tx_credit_cnt + 1;
            end
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    task automatic drive_bit(input logic b);
        drv_line <= b;
        repeat (BIT_CLKS) @(posedge Clk);  // Hold for one full bit period
    endtask

    // Sends start, data MSB first, the given parity bit and the given stop bits (bit 0 first)
    task automatic send_frame(input logic [uart_pkg::DATA_BITS-1:0] data, input logic par,
                              input logic [STOP_BITS-1:0] stops);
        @(posedge Clk);
        drive_bit(1'b0);
        for (int i = uart_pkg::DATA_BITS - 1; i >= 0; i--) begin
            drive_bit(data[i]);
        end
        drive_bit(par);
        for (int s = 0; s < STOP_BITS; s++) begin
            drive_bit(stops[s]);
        end
        drv_line <= 1'b1;  // Back to idle level
    endtask

    `include "uart_link_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before the test sequence finished");
    end

    initial begin
        void'($urandom(32'he155));
        Rst       = 1'b1;
        tx_valid  = 1'b0;
        tx_data   = '0;
        rx_credit = 1'b0;
        loopback  = 1'b0;
        drv_line  = 1'b1;
        repeat (RESET_CYCLES) @(posedge Clk);
        Rst <= 1'b0;
        test_reset_state();
        test_loopback_stream();
        test_line_errors();
        test_glitch_reject();
        test_flow_control();
        test_overrun();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* sim.f */
+incdir+sim
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_host_port.sv
hw/uart_link.sv
sim/uart_link_tb.sv

/* Bender.yml */
package:
  name: uart_link

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/uart_fifo.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/uart_host_port.sv
      - hw/uart_link.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/uart_link_tb.sv
